// File: Makefile
# Verilator simulation of the inverter control core

VERILATOR ?= verilator
TOP       ?= inverter_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/command_receiver.sv
`timescale 1ns/10ps

module command_receiver
    import link_pkg::*;
    import drive_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ready,
    input  logic [DATA_BITS-1:0] rx_data,
    input  logic                 rx_done,
    input  logic                 rx_parity_err,
    output logic [ANGLE_W-1:0]   angle,
    output logic                 fault,
    output logic                 led_red,
    output logic                 led_blue
);

    typedef enum logic {
        WAIT_HI,
        WAIT_LO
    } byte_state_t;

    byte_state_t          byte_state;
    logic [DATA_BITS-1:0] hi_byte_q;
    cmd_word_t            cmd_word;
    logic                 accept;

    // Deaf during startup and after a fault
    assign accept = rx_done && ready && !fault;

    // Word as it stands once the second byte arrives
    always_comb begin
        cmd_word.bytes.hi_byte = hi_byte_q;
        cmd_word.bytes.lo_byte = rx_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_state <= WAIT_HI;
            angle      <= '0;
            fault      <= 1'b0;
        end else if (accept) begin
            if (rx_parity_err) begin
                // Partial word is dropped
                fault      <= 1'b1;
                byte_state <= WAIT_HI;
            end else if (byte_state == WAIT_HI) begin
                byte_state <= WAIT_LO;
            end else begin
                byte_state <= WAIT_HI;
                if (cmd_word.fields.code == CMD_SET_ANGLE) begin
                    angle <= cmd_word.fields.angle;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !rx_parity_err && byte_state == WAIT_HI) begin
            hi_byte_q <= rx_data;
        end
    end

    // Active-low LEDs
    assign led_blue = ~(ready & ~fault);
    assign led_red  = ~fault;

    a_fault_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        fault |=> fault);

endmodule

// File: rtl/drive_pkg.sv
package drive_pkg;

    localparam int ANGLE_W      = 12;
    localparam int SECTOR_WIDTH = 683;
    localparam int NUM_SECTORS  = 6;

    typedef logic [2:0] sector_t;

    // One bit per leg, bit 0 is leg A
    typedef logic [2:0] leg_pattern_t;

    localparam leg_pattern_t LEG_NONE = 3'b000;
    localparam leg_pattern_t LEG_A    = 3'b001;
    localparam leg_pattern_t LEG_B    = 3'b010;
    localparam leg_pattern_t LEG_C    = 3'b100;

    // Six-step commutation, high-side leg per sector
    function automatic leg_pattern_t sector_hi(sector_t sector);
        case (sector)
            3'd0, 3'd1: return LEG_A;
            3'd2, 3'd3: return LEG_B;
            3'd4, 3'd5: return LEG_C;
            default:    return LEG_NONE;
        endcase
    endfunction

    // Low-side leg per sector
    function automatic leg_pattern_t sector_lo(sector_t sector);
        case (sector)
            3'd0:       return LEG_B;
            3'd1, 3'd2: return LEG_C;
            3'd3, 3'd4: return LEG_A;
            3'd5:       return LEG_B;
            default:    return LEG_NONE;
        endcase
    endfunction

endpackage

// File: rtl/inverter_top.sv
`timescale 1ns/10ps

module inverter_top
    import link_pkg::*;
    import drive_pkg::*;
#(
    parameter int CLKS_PER_BIT   = 417,
    parameter int STARTUP_CYCLES = 48_000_000,
    parameter int DEAD_CYCLES    = 24
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    input  logic       shoot,
    output logic [2:0] gate_hi,
    output logic [2:0] gate_lo,
    output logic       led_red,
    output logic       led_blue
);

    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_done;
    logic                 rx_parity_err;
    logic                 ready;
    logic                 fault;
    logic [ANGLE_W-1:0]   angle;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx            (rx),
        .rx_data       (rx_data),
        .rx_done       (rx_done),
        .rx_parity_err (rx_parity_err)
    );

    // Holds the receiver off after power-up
    startup_timer #(
        .STARTUP_CYCLES(STARTUP_CYCLES)
    ) u_startup_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .ready (ready)
    );

    command_receiver u_command_receiver (
        .clk           (clk),
        .rst_n         (rst_n),
        .ready         (ready),
        .rx_data       (rx_data),
        .rx_done       (rx_done),
        .rx_parity_err (rx_parity_err),
        .angle         (angle),
        .fault         (fault),
        .led_red       (led_red),
        .led_blue      (led_blue)
    );

    phase_modulator #(
        .DEAD_CYCLES(DEAD_CYCLES)
    ) u_phase_modulator (
        .clk     (clk),
        .rst_n   (rst_n),
        .angle   (angle),
        .fault   (fault),
        .shoot   (shoot),
        .gate_hi (gate_hi),
        .gate_lo (gate_lo)
    );

endmodule

// File: rtl/link_pkg.sv
package link_pkg;

    // Payload bits in one serial frame
    localparam int DATA_BITS = 8;

    // Command word layout
    localparam int CMD_CODE_W = 4;
    localparam int CMD_WORD_W = 2 * DATA_BITS;
    localparam int CMD_ARG_W  = CMD_WORD_W - CMD_CODE_W;

    typedef logic [CMD_CODE_W-1:0] cmd_code_t;

    // The one code acted upon
    localparam cmd_code_t CMD_SET_ANGLE = 4'd1;

    // First byte on the wire lands in the upper half
    typedef struct packed {
        logic [DATA_BITS-1:0] hi_byte;
        logic [DATA_BITS-1:0] lo_byte;
    } cmd_bytes_t;

    typedef struct packed {
        cmd_code_t            code;
        logic [CMD_ARG_W-1:0] angle;
    } cmd_fields_t;

    typedef union packed {
        cmd_bytes_t  bytes;
        cmd_fields_t fields;
    } cmd_word_t;

endpackage

// File: rtl/phase_modulator.sv
`timescale 1ns/10ps

module phase_modulator
    import drive_pkg::*;
#(
    parameter int DEAD_CYCLES = 24
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [ANGLE_W-1:0] angle,
    input  logic               fault,
    input  logic               shoot,
    output logic [2:0]         gate_hi,
    output logic [2:0]         gate_lo
);

    localparam int DEAD_W = $clog2(DEAD_CYCLES + 1);
    localparam logic [DEAD_W-1:0] DEAD_LAST = DEAD_W'(DEAD_CYCLES - 1);

    sector_t           sector_next;
    sector_t           sector;
    leg_pattern_t      target_hi;
    leg_pattern_t      target_lo;
    leg_pattern_t      applied_hi;
    leg_pattern_t      applied_lo;
    logic [DEAD_W-1:0] dead_cnt;
    logic              dead_active;
    logic              enable;

    // Threshold compare, angles past the last boundary stay in sector 5
    always_comb begin
        sector_next = '0;
        for (int i = 1; i < NUM_SECTORS; i++) begin
            if (angle >= ANGLE_W'(i * SECTOR_WIDTH)) begin
                sector_next = sector_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sector <= '0;
        end else begin
            sector <= sector_next;
        end
    end

    assign target_hi = sector_hi(sector);
    assign target_lo = sector_lo(sector);

    assign enable = shoot && !fault;

    // Blanking between patterns
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            applied_hi  <= LEG_NONE;
            applied_lo  <= LEG_NONE;
            dead_cnt    <= '0;
            dead_active <= 1'b0;
        end else if (!enable) begin
            // Pattern cleared so re-enable starts with dead time
            applied_hi  <= LEG_NONE;
            applied_lo  <= LEG_NONE;
            dead_cnt    <= '0;
            dead_active <= 1'b0;
        end else if (dead_active) begin
            if (dead_cnt == DEAD_LAST) begin
                // Latest target wins
                applied_hi  <= target_hi;
                applied_lo  <= target_lo;
                dead_cnt    <= '0;
                dead_active <= 1'b0;
            end else begin
                dead_cnt <= dead_cnt + 1'b1;
            end
        end else if (target_hi != applied_hi || target_lo != applied_lo) begin
            applied_hi  <= LEG_NONE;
            applied_lo  <= LEG_NONE;
            dead_cnt    <= '0;
            dead_active <= 1'b1;
        end
    end

    // Shoot and fault cut the gates in the same cycle
    assign gate_hi = applied_hi & {3{enable}};
    assign gate_lo = applied_lo & {3{enable}};

    // No shoot-through on any leg
    a_no_shoot_through: assert property (@(posedge clk)
        (gate_hi & gate_lo) == 3'b000);

    // Fault from the receiver keeps the bridge off
    a_fault_gates_off: assert property (@(posedge clk) disable iff (!rst_n)
        fault |-> (gate_hi | gate_lo) == 3'b000);

endmodule

// File: rtl/startup_timer.sv
`timescale 1ns/10ps

module startup_timer #(
    parameter int STARTUP_CYCLES = 48_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic ready
);

    localparam int CNT_W = $clog2(STARTUP_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(STARTUP_CYCLES - 1);

    logic [CNT_W-1:0] count;

    // Counter stops once ready is up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            if (count == LAST_COUNT) begin
                ready <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = 417
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_done,
    output logic                 rx_parity_err
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_BITS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_t;

    state_t               state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic [CNT_W-1:0]     bit_cnt;
    logic [IDX_W-1:0]     bit_idx;
    logic                 bit_end;
    logic [DATA_BITS-1:0] shift_reg;
    logic                 parity_bit;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign bit_end = (bit_cnt == FULL_BIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            bit_cnt       <= '0;
            bit_idx       <= '0;
            rx_done       <= 1'b0;
            rx_parity_err <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        state <= S_START;
                    end
                end
                // Wait to the middle of the start bit
                S_START: begin
                    if (bit_cnt == HALF_BIT) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // Line back high means a glitch
                        state   <= rx_sync ? S_IDLE : S_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_IDX) begin
                            state <= S_PARITY;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_PARITY: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        state   <= S_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                // Mid-stop sample, low stop bit is reported as an error too
                S_STOP: begin
                    if (bit_end) begin
                        rx_done       <= 1'b1;
                        rx_parity_err <= (^{shift_reg, parity_bit}) | ~rx_sync;
                        state         <= S_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
        end
        if (state == S_PARITY && bit_end) begin
            parity_bit <= rx_sync;
        end
        if (state == S_STOP && bit_end) begin
            rx_data <= shift_reg;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done);

endmodule

// File: src.f
rtl/link_pkg.sv
rtl/drive_pkg.sv
rtl/uart_rx.sv
rtl/startup_timer.sv
rtl/command_receiver.sv
rtl/phase_modulator.sv
rtl/inverter_top.sv
tests/clock_gen.sv
tests/inverter_tb.sv

// File: tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release a little after the edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// File: tests/inverter_tb.sv
`timescale 1ns/10ps

module inverter_tb
    import link_pkg::*;
    import drive_pkg::*;
;

    localparam int PERIOD_NS      = 40;
    localparam int CLKS_PER_BIT   = 8;
    localparam int STARTUP_CYCLES = 50;
    localparam int DEAD_CYCLES    = 4;
    localparam int SETTLE_CYCLES  = 40;
    localparam int unsigned SEED  = 32'h995c_fa36;

    logic       clk;
    logic       rst_n;
    logic       rx;
    logic       shoot;
    logic [2:0] gate_hi;
    logic [2:0] gate_lo;
    logic       led_red;
    logic       led_blue;

    // Stimulus table
    string      row_name[$];
    logic [7:0] row_hi[$];
    logic [7:0] row_lo[$];
    bit         row_bad[$];
    bit         row_shoot[$];
    logic [2:0] row_exp_hi[$];
    logic [2:0] row_exp_lo[$];
    bit         row_exp_fault[$];

    // Reference model state used while the table is built
    logic [11:0] model_angle = '0;
    bit          model_fault = 1'b0;
    bit          table_built = 1'b0;

    int checks         = 0;
    int errors         = 0;
    int monitor_errors = 0;
    int dead_seen      = 0;
    int low_run        = 0;
    logic [5:0] prev_gates = '0;

    clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    inverter_top #(
        .CLKS_PER_BIT   (CLKS_PER_BIT),
        .STARTUP_CYCLES (STARTUP_CYCLES),
        .DEAD_CYCLES    (DEAD_CYCLES)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .shoot    (shoot),
        .gate_hi  (gate_hi),
        .gate_lo  (gate_lo),
        .led_red  (led_red),
        .led_blue (led_blue)
    );

    function automatic int expected_sector(logic [11:0] angle);
        int sector;
        sector = int'(angle) / SECTOR_WIDTH;
        if (sector > NUM_SECTORS - 1) begin
            sector = NUM_SECTORS - 1;
        end
        return sector;
    endfunction

    // {high legs, low legs}, bit 0 is leg A
    function automatic logic [5:0] commutation(int sector);
        case (sector)
            0:       return {3'b001, 3'b010};
            1:       return {3'b001, 3'b100};
            2:       return {3'b010, 3'b100};
            3:       return {3'b010, 3'b001};
            4:       return {3'b100, 3'b001};
            5:       return {3'b100, 3'b010};
            default: return 6'b000000;
        endcase
    endfunction

    task automatic add_row(input string name, input logic [3:0] code, input int angle_val,
                           input bit bad, input bit shoot_val);
        logic [11:0] angle;
        logic [5:0]  pattern;
        angle = angle_val[11:0];
        if (bad) begin
            model_fault = 1'b1;
        end else if (!model_fault && code == CMD_SET_ANGLE) begin
            model_angle = angle;
        end
        pattern = commutation(expected_sector(model_angle));
        if (model_fault || !shoot_val) begin
            pattern = '0;
        end
        row_name.push_back(name);
        row_hi.push_back({code, angle[11:8]});
        row_lo.push_back(angle[7:0]);
        row_bad.push_back(bad);
        row_shoot.push_back(shoot_val);
        row_exp_hi.push_back(pattern[5:3]);
        row_exp_lo.push_back(pattern[2:0]);
        row_exp_fault.push_back(model_fault);
    endtask

    task automatic build_table();
        add_row("angle_0", CMD_SET_ANGLE, 0, 1'b0, 1'b1);
        add_row("angle_682", CMD_SET_ANGLE, 682, 1'b0, 1'b1);
        add_row("angle_683", CMD_SET_ANGLE, 683, 1'b0, 1'b1);
        add_row("angle_1365", CMD_SET_ANGLE, 1365, 1'b0, 1'b1);
        add_row("angle_1366", CMD_SET_ANGLE, 1366, 1'b0, 1'b1);
        add_row("angle_2048", CMD_SET_ANGLE, 2048, 1'b0, 1'b1);
        add_row("angle_2049", CMD_SET_ANGLE, 2049, 1'b0, 1'b1);
        add_row("angle_2731", CMD_SET_ANGLE, 2731, 1'b0, 1'b1);
        add_row("angle_2732", CMD_SET_ANGLE, 2732, 1'b0, 1'b1);
        add_row("angle_3414", CMD_SET_ANGLE, 3414, 1'b0, 1'b1);
        add_row("angle_3415", CMD_SET_ANGLE, 3415, 1'b0, 1'b1);
        add_row("angle_4095", CMD_SET_ANGLE, 4095, 1'b0, 1'b1);
        // Unknown code keeps the last pattern, its angle lies in another sector
        add_row("other_code", 4'h2, 1000, 1'b0, 1'b1);
        add_row("random_0", CMD_SET_ANGLE, int'($urandom_range(4095, 0)), 1'b0, 1'b1);
        add_row("random_1", CMD_SET_ANGLE, int'($urandom_range(4095, 0)), 1'b0, 1'b1);
        add_row("random_2", CMD_SET_ANGLE, int'($urandom_range(4095, 0)), 1'b0, 1'b1);
        add_row("shoot_low", CMD_SET_ANGLE, 1000, 1'b0, 1'b0);
        add_row("shoot_again", CMD_SET_ANGLE, 100, 1'b0, 1'b1);
        add_row("bad_parity", CMD_SET_ANGLE, 3000, 1'b1, 1'b1);
    endtask

    // Start, 8 data bits LSB first, even parity, stop
    task automatic send_frame(input logic [7:0] data, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            rx = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #2;
        end
    endtask

    task automatic check_outputs(input string name, input logic [2:0] exp_hi,
                                 input logic [2:0] exp_lo, input logic exp_red,
                                 input logic exp_blue);
        checks += 4;
        if (gate_hi !== exp_hi) begin
            $display("FAIL %s: gate_hi expected %b, actual %b", name, exp_hi, gate_hi);
            errors++;
        end
        if (gate_lo !== exp_lo) begin
            $display("FAIL %s: gate_lo expected %b, actual %b", name, exp_lo, gate_lo);
            errors++;
        end
        if (led_red !== exp_red) begin
            $display("FAIL %s: led_red expected %b, actual %b", name, exp_red, led_red);
            errors++;
        end
        if (led_blue !== exp_blue) begin
            $display("FAIL %s: led_blue expected %b, actual %b", name, exp_blue, led_blue);
            errors++;
        end
    endtask

    // Shoot-through and dead-time monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if ((gate_hi & gate_lo) != 3'b000) begin
                $display("Error: high and low gate of one leg on together at %0t", $time);
                monitor_errors++;
            end
            if ({gate_hi, gate_lo} == 6'b000000) begin
                low_run++;
            end else begin
                if (low_run == 0 && {gate_hi, gate_lo} != prev_gates) begin
                    $display("Error: gate pattern changed with no dead time at %0t", $time);
                    monitor_errors++;
                end else if (low_run > 0 && low_run < DEAD_CYCLES) begin
                    $display("Error: dead time of %0d cycles is too short at %0t",
                             low_run, $time);
                    monitor_errors++;
                end
                if (low_run > 0 && prev_gates != 6'b000000 && {gate_hi, gate_lo} != prev_gates) begin
                    dead_seen++;
                end
                low_run = 0;
                prev_gates = {gate_hi, gate_lo};
            end
        end
    end

    initial begin
        int limit_ns;
        wait (table_built);
        // Two frames plus settling per row, two extra rows for startup and the fault check
        limit_ns = (row_name.size() + 2) * (2 * 11 * CLKS_PER_BIT + 60) * PERIOD_NS * 2;
        #(limit_ns);
        $display("Error: run did not finish within %0d ns", limit_ns);
        $display("checks: %0d, errors: %0d", checks, errors + monitor_errors + 1);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int unsigned seed_init;
        int          total;
        rx = 1'b1;
        shoot = 1'b0;
        seed_init = $urandom(SEED);
        build_table();
        table_built = 1'b1;

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_outputs("startup_reset", 3'b000, 3'b000, 1'b1, 1'b1);
        repeat (STARTUP_CYCLES + 2) @(posedge clk);
        @(negedge clk);
        check_outputs("startup_ready", 3'b000, 3'b000, 1'b1, 1'b0);
        @(posedge clk);
        #2;

        for (int i = 0; i < row_name.size(); i++) begin
            shoot = row_shoot[i];
            send_frame(row_hi[i], row_bad[i]);
            send_frame(row_lo[i], 1'b0);
            repeat (SETTLE_CYCLES) @(posedge clk);
            @(negedge clk);
            check_outputs(row_name[i], row_exp_hi[i], row_exp_lo[i],
                          ~row_exp_fault[i], row_exp_fault[i]);
            @(posedge clk);
            #2;
        end

        // A valid command after the fault must change nothing
        send_frame({CMD_SET_ANGLE, 4'h4}, 1'b0);
        send_frame(8'h00, 1'b0);
        repeat (SETTLE_CYCLES) @(posedge clk);
        @(negedge clk);
        check_outputs("after_fault", 3'b000, 3'b000, 1'b0, 1'b1);

        if (dead_seen == 0) begin
            $display("Error: no dead-time interval between two patterns was seen");
            errors++;
        end

        total = errors + monitor_errors;
        $display("checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
